// ==== run_sim.sh ====
#!/bin/sh
# builds the trace encoder testbench with Verilator and runs it
# a failing check ends in $fatal, so the exit status carries the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    -f tb.f \
    --top-module tb_trace_encoder \
    -Mdir obj_dir

./obj_dir/Vtb_trace_encoder

// ==== tb.f ====
+incdir+verification
verilog/te_pkg.sv
verilog/te_stage_if.sv
verilog/te_input_pipe.sv
verilog/te_itype_detector.sv
verilog/te_branch_map.sv
verilog/te_priority.sv
verilog/te_packet_emitter.sv
verilog/trace_encoder.sv
verification/tb_trace_encoder.sv

// ==== verification/tb_tasks.svh ====
/* trace encoder testbench tasks
   stream building, driving, waiting, packet compares and the directed tests */

task automatic check_type(input te_ptype_t got, input te_ptype_t exp);
    if (got !== exp) begin
        fail_run($sformatf("Error: time %0t packet_type_o got %h expected %h", $time, got, exp));
    end
endtask

task automatic check_length(input te_plen_t got, input te_plen_t exp);
    if (got !== exp) begin
        fail_run($sformatf("Error: time %0t packet_length_o got %h expected %h",
                           $time, got, exp));
    end
endtask

task automatic check_payload(input te_payload_t got, input te_payload_t exp);
    if (got !== exp) begin
        fail_run($sformatf("Error: time %0t packet_payload_o got %h expected %h",
                           $time, got, exp));
    end
endtask

// cycles from the first drive of the stream to packet_valid_o
task automatic check_latency(input int unsigned got, input int unsigned exp);
    if (got != exp) begin
        fail_run($sformatf("Error: time %0t packet_valid_o cycle got %0d expected %0d",
                           $time, got, exp));
    end
endtask

// one retired instruction, qualified by the enable it goes with
task automatic push_rec(input logic en, input logic [31:0] pc, input logic [31:0] inst,
                        input logic exc, input logic intr, input logic [4:0] cause);
    te_inst_rec_t r;
    r.valid     = 1'b1;
    r.qualified = en;
    r.pc        = pc;
    r.inst      = inst;
    r.priv      = cur_priv;
    r.exception = exc;
    r.interrupt = intr;
    r.cause     = cause;
    stream_q.push_back(r);
    enable_q.push_back(en);
endtask

task automatic push_idle(input int n);
    te_inst_rec_t r;
    r = '0;
    repeat (n) begin
        stream_q.push_back(r);
        enable_q.push_back(1'b0);
    end
endtask

task automatic push_seq(input logic en, inout logic [31:0] pc, input int n);
    repeat (n) begin
        push_rec(en, pc, INST_NOP, 1'b0, 1'b0, 5'd0);
        pc = pc + 32'd4;
    end
endtask

// outcome from the lfsr, taken jumps over one instruction
task automatic push_branches(inout logic [31:0] pc, input int n);
    repeat (n) begin
        lfsr_state = lfsr_step(lfsr_state);
        push_rec(1'b1, pc, INST_BEQ, 1'b0, 1'b0, 5'd0);
        pc = lfsr_state[0] ? pc + 32'd8 : pc + 32'd4;
    end
endtask

task automatic drive_stream();
    te_inst_rec_t r;
    int           i;
    for (i = 0; i < stream_q.size(); i++) begin
        r = stream_q[i];
        @(posedge clk_i);
        #1;
        // packet cycles count from here
        if (i == 0) begin
            stream_start = cycle_no;
        end
        inst_valid_i   = r.valid;
        trace_enable_i = enable_q[i];
        exception_i    = r.exception;
        interrupt_i    = r.interrupt;
        cause_i        = r.cause;
        priv_lvl_i     = r.priv;
        inst_data_i    = r.inst;
        pc_i           = r.pc;
    end
endtask

task automatic wait_packets_done(input string name);
    int unsigned cycles;
    cycles = 0;
    while (exp_type_q.size() != 0 && cycles < TIMEOUT_CYCLES) begin
        @(negedge clk_i);
        cycles++;
    end
    if (exp_type_q.size() != 0) begin
        fail_run($sformatf("%s timed out with %0d packets never sent",
                           name, exp_type_q.size()));
    end
endtask

task automatic run_stream(input string name);
    build_expected();
    drive_stream();
    wait_packets_done(name);
    stream_q.delete();
    enable_q.delete();
endtask

task automatic test_start_of_trace();
    logic [31:0] pc;
    pc = 32'h8000_0000;
    // trace off, nothing may come out
    push_seq(1'b0, pc, 6);
    push_seq(1'b1, pc, 8);
    push_idle(3);
    run_stream("start of trace");
endtask

task automatic test_branches_and_jalr();
    logic [31:0] pc;
    pc = 32'h8000_1000;
    push_seq(1'b1, pc, 2);
    push_branches(pc, 8);
    push_rec(1'b1, pc, INST_JALR, 1'b0, 1'b0, 5'd0);
    pc = 32'h8000_2400;
    push_seq(1'b1, pc, 3);
    // second jalr finds the map empty
    push_rec(1'b1, pc, INST_JALR, 1'b0, 1'b0, 5'd0);
    pc = 32'h8000_3000;
    push_seq(1'b1, pc, 3);
    push_idle(3);
    run_stream("branches and jalr");
endtask

task automatic test_full_map();
    logic [31:0] pc;
    pc = 32'h8000_4000;
    push_seq(1'b1, pc, 1);
    push_branches(pc, 31);
    push_seq(1'b1, pc, 2);
    push_idle(3);
    run_stream("full branch map");
endtask

task automatic test_trap();
    logic [31:0] pc;
    cur_priv = 2'b00;
    pc       = 32'h8000_5000;
    push_seq(1'b1, pc, 3);
    // faulting beq, never counted as branch
    push_rec(1'b1, pc, INST_BEQ, 1'b1, 1'b0, 5'd2);
    cur_priv = 2'b11;
    pc       = 32'h8000_0100;
    push_seq(1'b1, pc, 2);
    push_rec(1'b1, pc, INST_NOP, 1'b1, 1'b1, 5'd7);
    pc = 32'h8000_0200;
    push_seq(1'b1, pc, 2);
    push_idle(3);
    run_stream("trap");
endtask

task automatic test_end_of_trace();
    logic [31:0] pc;
    pc = 32'h8000_6000;
    push_seq(1'b1, pc, 2);
    push_branches(pc, 3);
    push_seq(1'b1, pc, 1);
    push_seq(1'b0, pc, 6);
    // second window without branches
    push_seq(1'b1, pc, 3);
    push_seq(1'b0, pc, 6);
    push_idle(3);
    run_stream("end of trace");
endtask

// ==== verification/tb_trace_encoder.sv ====
/* tb_trace_encoder
   directed tests for the trace encoder, packets checked against a rule model */
`timescale 1ns/1ps
`default_nettype none

module tb_trace_encoder import te_pkg::*; ();

    localparam int unsigned TIMEOUT_CYCLES = 200;

    // rv32 encodings used in the streams
    localparam logic [31:0] INST_NOP  = 32'h0000_0013;
    localparam logic [31:0] INST_BEQ  = 32'h00b5_0463;
    localparam logic [31:0] INST_JALR = 32'h0000_80e7;

    logic                 clk_i;
    logic                 rst_ni;
    logic                 inst_valid_i;
    logic                 trace_enable_i;
    logic                 exception_i;
    logic                 interrupt_i;
    logic [CAUSE_LEN-1:0] cause_i;
    logic [PRIV_LEN-1:0]  priv_lvl_i;
    logic [INST_LEN-1:0]  inst_data_i;
    logic [XLEN-1:0]      pc_i;
    logic                 packet_valid_o;
    te_ptype_t            packet_type_o;
    te_plen_t             packet_length_o;
    te_payload_t          packet_payload_o;

    // stream of one test, enable per entry
    te_inst_rec_t stream_q[$];
    logic         enable_q[$];
    // packets still owed by the DUT, oldest first
    te_ptype_t    exp_type_q[$];
    te_plen_t     exp_len_q[$];
    te_payload_t  exp_payload_q[$];
    // negedges from the first drive of the stream to each packet
    int unsigned  exp_cycle_q[$];
    logic [31:0]  lfsr_state;
    logic [1:0]   cur_priv;
    int unsigned  cycle_no;
    int unsigned  stream_start;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // walks the stream with the encoder rules and queues the packets
    task automatic build_expected();
        te_inst_rec_t tc;
        te_inst_rec_t nc;
        te_inst_rec_t lc;
        logic [4:0]   count;
        logic [30:0]  map;
        logic         lc_jalr;
        logic         branch;
        logic         taken;
        logic         emit;
        te_ptype_t    ptype;
        te_plen_t     plen;
        te_payload_t  pay;
        int           i;
        count = '0;
        map   = '0;
        for (i = 0; i < stream_q.size(); i++) begin
            tc = stream_q[i];
            lc = '0;
            nc = '0;
            if (i > 0) lc = stream_q[i-1];
            if (i + 1 < stream_q.size()) nc = stream_q[i+1];
            lc_jalr = lc.qualified && !lc.exception && (lc.inst[6:0] == 7'h67);
            branch  = tc.qualified && !tc.exception && (tc.inst[6:0] == 7'h63);
            taken   = nc.valid && (nc.pc != tc.pc + 32'd4);
            // tc branch joins the map before the decision
            if (branch) begin
                map[count] = !taken;
                count      = count + 5'd1;
            end
            emit            = tc.qualified;
            plen            = '0;
            pay             = '0;
            ptype.format    = F_BRANCH_FULL;
            ptype.subformat = SF_START;
            if (!tc.qualified) begin
                emit = 1'b0;
            end else if (lc.exception) begin
                ptype.format    = F_SYNC;
                ptype.subformat = SF_TRAP;
                plen            = 4'd9;
                pay[1:0]        = lc.priv;
                pay[6:2]        = lc.cause;
                pay[7]          = lc.interrupt;
                pay[39:8]       = tc.pc;
                pay[71:40]      = lc.pc;
            end else if (!lc.qualified) begin
                ptype.format = F_SYNC;
                plen         = 4'd5;
                pay[1:0]     = tc.priv;
                pay[33:2]    = tc.pc;
            end else if (lc_jalr || !nc.qualified) begin
                if (count != 5'd0) begin
                    plen       = 4'd9;
                    pay[4:0]   = count;
                    pay[35:5]  = map;
                    pay[67:36] = tc.pc;
                end else begin
                    ptype.format = F_ADDR_ONLY;
                    plen         = 4'd4;
                    pay[31:0]    = tc.pc;
                end
            end else if (count == 5'd31) begin
                plen      = 4'd5;
                pay[4:0]  = count;
                pay[35:5] = map;
            end else begin
                emit = 1'b0;
            end
            if (emit) begin
                exp_type_q.push_back(ptype);
                exp_len_q.push_back(plen);
                exp_payload_q.push_back(pay);
                // sampled one edge after driving, packet out for the cycle after two more
                exp_cycle_q.push_back(i + 4);
                count = '0;
                map   = '0;
            end
        end
    endtask

    `include "tb_tasks.svh"

    trace_encoder uut (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .inst_valid_i     (inst_valid_i),
        .trace_enable_i   (trace_enable_i),
        .exception_i      (exception_i),
        .interrupt_i      (interrupt_i),
        .cause_i          (cause_i),
        .priv_lvl_i       (priv_lvl_i),
        .inst_data_i      (inst_data_i),
        .pc_i             (pc_i),
        .packet_valid_o   (packet_valid_o),
        .packet_type_o    (packet_type_o),
        .packet_length_o  (packet_length_o),
        .packet_payload_o (packet_payload_o)
    );

    always #4 clk_i = ~clk_i;

    // outputs settle by mid cycle
    always @(negedge clk_i) begin
        cycle_no++;
        if (!rst_ni) begin
            // packet outputs held at zero in reset
            if (packet_valid_o !== 1'b0) begin
                fail_run($sformatf("Error: time %0t packet_valid_o got %b expected 0",
                                   $time, packet_valid_o));
            end
            check_type(packet_type_o, '0);
            check_length(packet_length_o, '0);
            check_payload(packet_payload_o, '0);
        end else if (packet_valid_o) begin
            if (exp_type_q.size() == 0) begin
                fail_run($sformatf("unexpected packet of type %h at time %0t",
                                   packet_type_o, $time));
            end else begin
                check_latency(cycle_no - stream_start, exp_cycle_q.pop_front());
                check_type(packet_type_o, exp_type_q.pop_front());
                check_length(packet_length_o, exp_len_q.pop_front());
                check_payload(packet_payload_o, exp_payload_q.pop_front());
            end
        end
    end

    initial begin
        clk_i            = 1'b0;
        rst_ni           = 1'b0;
        inst_valid_i     = 1'b0;
        trace_enable_i   = 1'b0;
        exception_i      = 1'b0;
        interrupt_i      = 1'b0;
        cause_i          = '0;
        priv_lvl_i       = '0;
        inst_data_i      = '0;
        pc_i             = '0;
        lfsr_state       = 32'hb4ec;
        cur_priv         = 2'b11;
        cycle_no         = 0;
        stream_start     = 0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        test_start_of_trace();
        test_branches_and_jalr();
        test_full_map();
        test_trap();
        test_end_of_trace();
        // room for a stray packet to show up
        repeat (4) @(negedge clk_i);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/te_branch_map.sv ====
/* te_branch_map
   collects branch outcomes, oldest in bit 0, and previews the map with tc included */
`timescale 1ns/1ps
`default_nettype none

module te_branch_map import te_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        record_i,
    input  logic                        taken_i,
    input  logic                        flush_i,
    output logic [BRANCH_COUNT_LEN-1:0] count_o,
    output logic [BRANCH_MAP_LEN-1:0]   map_o,
    output logic                        empty_next_o,
    output logic                        full_next_o
);

    logic [BRANCH_COUNT_LEN-1:0] count_next;

    // count once the current branch is in
    assign count_next = count_o + BRANCH_COUNT_LEN'(record_i);

    // preview for the priority, tc branch included
    assign empty_next_o = (count_next == '0);
    assign full_next_o  = (count_next == BRANCH_COUNT_LEN'(BRANCH_MAP_LEN));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_o <= '0;
            map_o   <= '0;
        end else if (flush_i) begin
            // flush beats a branch recorded in the same cycle
            count_o <= '0;
            map_o   <= '0;
        end else if (record_i) begin
            // 1 marks not taken
            map_o   <= map_o | (BRANCH_MAP_LEN'(!taken_i) << count_o);
            count_o <= count_next;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/te_input_pipe.sv ====
/* te_input_pipe
   samples one retirement record per cycle and shifts it through nc, tc and lc */
`timescale 1ns/1ps
`default_nettype none

module te_input_pipe import te_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 inst_valid_i,
    input  logic                 trace_enable_i,
    input  logic                 exception_i,
    input  logic                 interrupt_i,
    input  logic [CAUSE_LEN-1:0] cause_i,
    input  logic [PRIV_LEN-1:0]  priv_lvl_i,
    input  logic [INST_LEN-1:0]  inst_data_i,
    input  logic [XLEN-1:0]      pc_i,
    te_stage_if.pipe             stage_o
);

    te_inst_rec_t rec_d;

    // record as seen at the core boundary
    always_comb begin
        rec_d.valid     = inst_valid_i;
        // traced only while enabled
        rec_d.qualified = inst_valid_i & trace_enable_i;
        rec_d.pc        = pc_i;
        rec_d.inst      = inst_data_i;
        rec_d.priv      = priv_lvl_i;
        rec_d.exception = exception_i;
        rec_d.interrupt = interrupt_i;
        rec_d.cause     = cause_i;
    end

    // one cycle per stage
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            stage_o.nc <= '0;
            stage_o.tc <= '0;
            stage_o.lc <= '0;
        end else begin
            stage_o.nc <= rec_d;
            stage_o.tc <= stage_o.nc;
            stage_o.lc <= stage_o.tc;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/te_itype_detector.sv ====
/* te_itype_detector
   branch, branch outcome and uninferable discontinuity of the tc instruction */
`timescale 1ns/1ps
`default_nettype none

module te_itype_detector import te_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    te_stage_if.reader  stage_i,
    output logic        tc_branch_o,
    output logic        tc_taken_o,
    output logic        tc_updiscon_o,
    output logic        lc_updiscon_o
);

    logic [6:0] tc_opcode;
    logic       tc_traceable;

    assign tc_opcode = stage_i.tc.inst[6:0];

    // an excepting instruction never counts as branch or jump
    assign tc_traceable = stage_i.tc.qualified & ~stage_i.tc.exception;

    // qualification folded in, so this feeds the map directly
    assign tc_branch_o   = tc_traceable && (tc_opcode == OPCODE_BRANCH);
    assign tc_updiscon_o = tc_traceable && (tc_opcode == OPCODE_JALR);

    // taken when the next pc is not the sequential one
    assign tc_taken_o = stage_i.nc.valid && (stage_i.nc.pc != stage_i.tc.pc + XLEN'(4));

    // follows tc into lc
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lc_updiscon_o <= 1'b0;
        end else begin
            lc_updiscon_o <= tc_updiscon_o;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/te_packet_emitter.sv ====
/* te_packet_emitter
   packs payload and length for the chosen packet and registers the outputs */
`timescale 1ns/1ps
`default_nettype none

module te_packet_emitter import te_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    te_stage_if.reader                  stage_i,
    input  logic                        emit_i,
    input  te_format_e                  format_i,
    input  te_subformat_e               subformat_i,
    input  logic                        with_addr_i,
    input  logic [BRANCH_COUNT_LEN-1:0] count_i,
    input  logic [BRANCH_MAP_LEN-1:0]   map_i,
    input  logic                        tc_branch_i,
    input  logic                        tc_taken_i,
    output logic                        packet_valid_o,
    output te_ptype_t                   packet_type_o,
    output te_plen_t                    packet_length_o,
    output te_payload_t                 packet_payload_o
);

    logic [BRANCH_COUNT_LEN-1:0] count_m;
    logic [BRANCH_MAP_LEN-1:0]   map_m;
    te_ptype_t                   ptype_d;
    te_plen_t                    plen_d;
    te_payload_t                 payload_d;

    // bits rounded up to whole bytes
    function automatic te_plen_t bytes_of(input int unsigned bits);
        return te_plen_t'((bits + 7) / 8);
    endfunction

    // tc branch goes out with this packet
    always_comb begin
        count_m = count_i;
        map_m   = map_i;
        if (tc_branch_i) begin
            count_m = count_i + BRANCH_COUNT_LEN'(1);
            map_m   = map_i | (BRANCH_MAP_LEN'(!tc_taken_i) << count_i);
        end
    end

    // fields from bit 0 upward, rest stays zero
    always_comb begin
        ptype_d   = '0;
        plen_d    = '0;
        payload_d = '0;
        if (emit_i) begin
            ptype_d.format    = format_i;
            ptype_d.subformat = subformat_i;
            case (format_i)
                F_SYNC: begin
                    if (subformat_i == SF_TRAP) begin
                        // handler pc from tc, epc from lc
                        payload_d = te_payload_t'({stage_i.lc.pc, stage_i.tc.pc,
                                                   stage_i.lc.interrupt, stage_i.lc.cause,
                                                   stage_i.lc.priv});
                        plen_d    = bytes_of(TRAP_BITS);
                    end else begin
                        payload_d = te_payload_t'({stage_i.tc.pc, stage_i.tc.priv});
                        plen_d    = bytes_of(START_BITS);
                    end
                end
                F_BRANCH_FULL: begin
                    if (with_addr_i) begin
                        payload_d = te_payload_t'({stage_i.tc.pc, map_m, count_m});
                        plen_d    = bytes_of(BMAP_ADDR_BITS);
                    end else begin
                        payload_d = te_payload_t'({map_m, count_m});
                        plen_d    = bytes_of(BMAP_BITS);
                    end
                end
                F_ADDR_ONLY: begin
                    payload_d = te_payload_t'(stage_i.tc.pc);
                    plen_d    = bytes_of(ADDR_BITS);
                end
                default: begin
                    payload_d = '0;
                end
            endcase
        end
    end

    // one cycle strobe, zero between packets
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_o   <= 1'b0;
            packet_type_o    <= '0;
            packet_length_o  <= '0;
            packet_payload_o <= '0;
        end else begin
            packet_valid_o   <= emit_i;
            packet_type_o    <= ptype_d;
            packet_length_o  <= plen_d;
            packet_payload_o <= payload_d;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/te_pkg.sv ====
/* te_pkg
   widths, packet encodings and the stage record shared by the trace encoder */
`default_nettype none

package te_pkg;

    // core side widths
    localparam int unsigned XLEN      = 32;
    localparam int unsigned INST_LEN  = 32;
    localparam int unsigned CAUSE_LEN = 5;
    localparam int unsigned PRIV_LEN  = 2;

    // branch map capacity and count width
    localparam int unsigned BRANCH_MAP_LEN   = 31;
    localparam int unsigned BRANCH_COUNT_LEN = 5;

    // packet side widths
    localparam int unsigned PAYLOAD_LEN = 72;
    localparam int unsigned P_LEN       = 4;

    // rv32 major opcodes
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;

    // used payload bits per packet kind
    localparam int unsigned START_BITS     = PRIV_LEN + XLEN;
    localparam int unsigned TRAP_BITS      = PRIV_LEN + CAUSE_LEN + 1 + 2 * XLEN;
    localparam int unsigned ADDR_BITS      = XLEN;
    localparam int unsigned BMAP_BITS      = BRANCH_COUNT_LEN + BRANCH_MAP_LEN;
    localparam int unsigned BMAP_ADDR_BITS = BMAP_BITS + XLEN;

    // packet format
    typedef enum logic [1:0] {
        F_BRANCH_FULL = 2'h1,
        F_ADDR_ONLY   = 2'h2,
        F_SYNC        = 2'h3
    } te_format_e;

    // sync subformat
    typedef enum logic [1:0] {
        SF_START = 2'h0,
        SF_TRAP  = 2'h1
    } te_subformat_e;

    // format in the upper bits, subformat below
    typedef struct packed {
        te_format_e    format;
        te_subformat_e subformat;
    } te_ptype_t;

    typedef logic [PAYLOAD_LEN-1:0] te_payload_t;
    typedef logic [P_LEN-1:0]       te_plen_t;

    // one retirement record as held in a stage
    typedef struct packed {
        logic                 valid;
        logic                 qualified;
        logic [XLEN-1:0]      pc;
        logic [INST_LEN-1:0]  inst;
        logic [PRIV_LEN-1:0]  priv;
        logic                 exception;
        logic                 interrupt;
        logic [CAUSE_LEN-1:0] cause;
    } te_inst_rec_t;

endpackage

`default_nettype wire

// ==== verilog/te_priority.sv ====
/* te_priority
   decides whether the tc instruction needs a packet and of which kind */
`timescale 1ns/1ps
`default_nettype none

module te_priority import te_pkg::*; (
    te_stage_if.reader    stage_i,
    input  logic          lc_updiscon_i,
    input  logic          empty_next_i,
    input  logic          full_next_i,
    output logic          emit_o,
    output te_format_e    format_o,
    output te_subformat_e subformat_o,
    output logic          with_addr_o,
    output logic          flush_o
);

    logic first_qualified;
    logic final_qualified;

    // lc was outside the trace window
    assign first_qualified = ~stage_i.lc.qualified;
    // nc falls outside the trace window
    assign final_qualified = ~stage_i.nc.qualified;

    // first match wins
    always_comb begin
        emit_o      = 1'b0;
        format_o    = F_ADDR_ONLY;
        subformat_o = SF_START;
        with_addr_o = 1'b0;
        if (stage_i.tc.qualified) begin
            if (stage_i.lc.exception) begin
                // tc is the trap handler
                emit_o      = 1'b1;
                format_o    = F_SYNC;
                subformat_o = SF_TRAP;
            end else if (first_qualified) begin
                // start of trace
                emit_o      = 1'b1;
                format_o    = F_SYNC;
                subformat_o = SF_START;
            end else if (lc_updiscon_i || final_qualified) begin
                // jalr target or end of trace, address needed
                emit_o = 1'b1;
                if (!empty_next_i) begin
                    format_o    = F_BRANCH_FULL;
                    with_addr_o = 1'b1;
                end else begin
                    format_o = F_ADDR_ONLY;
                end
            end else if (full_next_i) begin
                // map full, no address
                emit_o   = 1'b1;
                format_o = F_BRANCH_FULL;
            end
        end
    end

    // every packet takes the pending branches with it
    assign flush_o = emit_o;

endmodule

`default_nettype wire

// ==== verilog/te_stage_if.sv ====
/* te_stage_if
   next, this and last cycle records from the input pipeline to its readers */
`timescale 1ns/1ps
`default_nettype none

interface te_stage_if import te_pkg::*; ();

    // next cycle, youngest record
    te_inst_rec_t nc;
    // this cycle, the one being decided on
    te_inst_rec_t tc;
    // last cycle
    te_inst_rec_t lc;

    // the pipeline owns all three stages
    modport pipe (
        output nc, tc, lc
    );

    // decoders, priority and emitter only look
    modport reader (
        input nc, tc, lc
    );

endinterface

`default_nettype wire

// ==== verilog/trace_encoder.sv ====
/* trace_encoder
   instruction trace encoder top, wires the stage pipe, decode, map,
   priority and packet emitter together */
`timescale 1ns/1ps
`default_nettype none

module trace_encoder import te_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 inst_valid_i,
    input  logic                 trace_enable_i,
    input  logic                 exception_i,
    input  logic                 interrupt_i,
    input  logic [CAUSE_LEN-1:0] cause_i,
    input  logic [PRIV_LEN-1:0]  priv_lvl_i,
    input  logic [INST_LEN-1:0]  inst_data_i,
    input  logic [XLEN-1:0]      pc_i,
    output logic                 packet_valid_o,
    output te_ptype_t            packet_type_o,
    output te_plen_t             packet_length_o,
    output te_payload_t          packet_payload_o
);

    // detector
    logic                        tc_branch;
    logic                        tc_taken;
    logic                        lc_updiscon;
    // branch map
    logic [BRANCH_COUNT_LEN-1:0] count;
    logic [BRANCH_MAP_LEN-1:0]   map;
    logic                        empty_next;
    logic                        full_next;
    // priority
    logic                        emit;
    te_format_e                  format;
    te_subformat_e               subformat;
    logic                        with_addr;
    logic                        flush;

    te_stage_if stage ();

    te_input_pipe i_input_pipe (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .inst_valid_i   (inst_valid_i),
        .trace_enable_i (trace_enable_i),
        .exception_i    (exception_i),
        .interrupt_i    (interrupt_i),
        .cause_i        (cause_i),
        .priv_lvl_i     (priv_lvl_i),
        .inst_data_i    (inst_data_i),
        .pc_i           (pc_i),
        .stage_o        (stage)
    );

    // only the lc copy of updiscon drives a decision
    te_itype_detector i_itype_detector (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .stage_i       (stage),
        .tc_branch_o   (tc_branch),
        .tc_taken_o    (tc_taken),
        .tc_updiscon_o (),
        .lc_updiscon_o (lc_updiscon)
    );

    // tc_branch already carries tc qualification
    te_branch_map i_branch_map (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .record_i     (tc_branch),
        .taken_i      (tc_taken),
        .flush_i      (flush),
        .count_o      (count),
        .map_o        (map),
        .empty_next_o (empty_next),
        .full_next_o  (full_next)
    );

    te_priority i_priority (
        .stage_i       (stage),
        .lc_updiscon_i (lc_updiscon),
        .empty_next_i  (empty_next),
        .full_next_i   (full_next),
        .emit_o        (emit),
        .format_o      (format),
        .subformat_o   (subformat),
        .with_addr_o   (with_addr),
        .flush_o       (flush)
    );

    te_packet_emitter i_packet_emitter (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .stage_i          (stage),
        .emit_i           (emit),
        .format_i         (format),
        .subformat_i      (subformat),
        .with_addr_i      (with_addr),
        .count_i          (count),
        .map_i            (map),
        .tc_branch_i      (tc_branch),
        .tc_taken_i       (tc_taken),
        .packet_valid_o   (packet_valid_o),
        .packet_type_o    (packet_type_o),
        .packet_length_o  (packet_length_o),
        .packet_payload_o (packet_payload_o)
    );

endmodule

`default_nettype wire
